// File: hdl/config_bank.sv
`timescale 1ns/1ps

module config_bank
(
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 ioctl_wr,
	input  logic [7:0]           ioctl_index,
	input  logic [24:0]          ioctl_addr,
	input  logic [7:0]           ioctl_dout,
	output game_pkg::game_e      game,
	output game_pkg::dip_t       dip,
	output game_pkg::board_cfg_t board
);
	import game_pkg::*;

	localparam int dip_sel_bits = $clog2(dip_count);

	logic game_wr;
	logic dip_wr;

	assign game_wr = ioctl_wr && (ioctl_index == dl_index_game);
	assign dip_wr  = ioctl_wr && (ioctl_index == dl_index_dip) &&
	                 (ioctl_addr < 25'(dip_count));

	// ============================================================
	// Download capture
	// ============================================================
	always_ff @(posedge clk_sys)
	begin
		if (reset)
		begin
			game <= game_scramble;
			dip  <= '1;	// All switches open
		end
		else
		begin
			if (game_wr)
			begin
				// Unknown numbers fall back to the default board
				if (game_known(ioctl_dout))
					game <= game_e'(ioctl_dout);
				else
					game <= game_scramble;
			end
			if (dip_wr)
				dip[ioctl_addr[dip_sel_bits-1:0]] <= ioctl_dout;
		end
	end

	// ============================================================
	// Board flags per game
	// ============================================================
	always_comb
	begin
		board = '0;
		case (game)
			game_frogger:
				board.hwsel = 8'd1;
			game_tazman:
				board.hwsel = 8'd2;
			game_calipso:
				board.hwsel = 8'd3;
			game_anteater:
				board.hwsel = 8'd6;
			game_losttomb:
			begin
				board.hwsel    = 8'd7;
				board.fourfire = 1'b1;
			end
			game_theend:
				board.galaxian_video = 1'b1;	// Stock hwsel with the other video
			game_stratgyx:
			begin
				board.hwsel     = 8'd5;
				board.landscape = 1'b1;
			end
			game_minefld:
			begin
				board.hwsel    = 8'd8;
				board.fourfire = 1'b1;
			end
			default: ;	// Scramble
		endcase
	end

	a_game_legal: assert property (@(posedge clk_sys) disable iff (reset) game_known(game))
		else $error("stored game number is not a known game");

endmodule

// File: hdl/game_pkg.sv
package game_pkg;

	// ============================================================
	// Game selection and board flags
	// ============================================================

	// Game numbers as sent in the download stream
	typedef enum logic [7:0] {
		game_scramble = 8'd0,
		game_frogger  = 8'd2,
		game_tazman   = 8'd4,
		game_calipso  = 8'd8,
		game_anteater = 8'd10,
		game_losttomb = 8'd11,
		game_theend   = 8'd12,
		game_stratgyx = 8'd14,
		game_minefld  = 8'd16
	} game_e;

	typedef struct packed {
		logic [7:0] hwsel;           // Hardware variant select
		logic       landscape;
		logic       fourfire;        // Four fire buttons, move+fire mode available
		logic       galaxian_video;
		logic       spare;
	} board_cfg_t;

	// Download indices
	localparam logic [7:0] dl_index_game = 8'd1;
	localparam logic [7:0] dl_index_dip  = 8'd254;

	localparam int dip_count = 4;

	// DIP bytes, index 0 masks port 0
	typedef logic [dip_count-1:0][7:0] dip_t;

	// True for a byte that names a supported game
	function automatic logic game_known(input logic [7:0] value);
		logic known;
		case (value)
			game_scramble, game_frogger, game_tazman,
			game_calipso, game_anteater, game_losttomb,
			game_theend, game_stratgyx, game_minefld:
				known = 1'b1;
			default:
				known = 1'b0;
		endcase
		return known;
	endfunction

endpackage

// File: hdl/input_ctrl_top.sv
`timescale 1ns/1ps

module input_ctrl_top
(
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic [10:0]          ps2_key,
	input  logic [31:0]          joy1,
	input  logic [31:0]          joy2,
	input  logic                 move_fire,
	input  logic                 ioctl_wr,
	input  logic [7:0]           ioctl_index,
	input  logic [24:0]          ioctl_addr,
	input  logic [7:0]           ioctl_dout,
	output input_pkg::ports_t    ports,
	output game_pkg::board_cfg_t board
);
	import input_pkg::*;
	import game_pkg::*;

	kbd_ctrl_t kbd;
	game_e     game;
	dip_t      dip;

	key_event_decoder u_key_event_decoder (
		.clk_sys (clk_sys),
		.reset   (reset),
		.ps2_key (ps2_key),
		.kbd     (kbd)
	);

	// Game number and DIP bytes from the download stream
	config_bank u_config_bank (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.ioctl_wr    (ioctl_wr),
		.ioctl_index (ioctl_index),
		.ioctl_addr  (ioctl_addr),
		.ioctl_dout  (ioctl_dout),
		.game        (game),
		.dip         (dip),
		.board       (board)
	);

	port_mapper u_port_mapper (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.kbd       (kbd),
		.joy1      (joy1),
		.joy2      (joy2),
		.move_fire (move_fire),
		.game      (game),
		.dip       (dip),
		.ports     (ports)
	);

endmodule

// File: hdl/input_pkg.sv
package input_pkg;

	// ============================================================
	// Player and system controls, all active high
	// ============================================================

	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic fire_a;
		logic fire_b;
		logic fire_c;
		logic fire_d;
		logic fire_e;
	} player_ctrl_t;

	typedef struct packed {
		logic start1;
		logic start2;
		logic coin;
	} system_ctrl_t;

	// Keyboard button levels; fire_c..fire_e stay low
	typedef struct packed {
		player_ctrl_t p1;
		player_ctrl_t p2;
		system_ctrl_t sys;
	} kbd_ctrl_t;

	// Board input ports, active low
	typedef struct packed {
		logic [7:0] port3;
		logic [7:0] port2;
		logic [7:0] port1;
		logic [7:0] port0;
	} ports_t;

	// PS/2 set 2 codes in use, bit 8 is the extended flag
	typedef enum logic [8:0] {
		key_up        = 9'h075,	// Arrows match with or without E0
		key_down      = 9'h072,
		key_left      = 9'h06B,
		key_right     = 9'h074,
		key_space     = 9'h029,
		key_ctrl      = 9'h014,
		key_f1        = 9'h005,
		key_f2        = 9'h006,
		key_1         = 9'h016,
		key_2         = 9'h01E,
		key_coin_5    = 9'h02E,
		key_coin_6    = 9'h036,
		key_p2_up     = 9'h02D,	// R
		key_p2_down   = 9'h02B,	// F
		key_p2_left   = 9'h023,	// D
		key_p2_right  = 9'h034,	// G
		key_p2_fire_a = 9'h01C,	// A
		key_p2_fire_b = 9'h01B	// S
	} key_code_e;

	// Joystick word bits shared by both players
	localparam int joy_start1_bit = 8;
	localparam int joy_start2_bit = 9;
	localparam int joy_coin_bit   = 10;

endpackage

// File: hdl/key_event_decoder.sv
`timescale 1ns/1ps

module key_event_decoder
(
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic [10:0]          ps2_key,
	output input_pkg::kbd_ctrl_t kbd
);
	import input_pkg::*;

	logic       toggle_prev;	// Event toggle seen last clock
	logic       event_seen;
	logic       pressed;
	logic [8:0] norm_code;

	assign event_seen = (toggle_prev != ps2_key[10]);
	assign pressed    = ps2_key[9];

	// Arrow keys arrive with or without the extended prefix
	always_comb
	begin
		norm_code = ps2_key[8:0];
		if ({1'b0, ps2_key[7:0]} inside {key_up, key_down, key_left, key_right})
			norm_code = {1'b0, ps2_key[7:0]};
	end

	// ============================================================
	// Button levels follow press and release events
	// ============================================================
	always_ff @(posedge clk_sys)
	begin
		if (reset)
		begin
			toggle_prev <= ps2_key[10];	// No event on reset release
			kbd         <= '0;
		end
		else
		begin
			toggle_prev <= ps2_key[10];
			if (event_seen)
			begin
				case (norm_code)
					key_up:        kbd.p1.up      <= pressed;
					key_down:      kbd.p1.down    <= pressed;
					key_left:      kbd.p1.left    <= pressed;
					key_right:     kbd.p1.right   <= pressed;
					key_ctrl:      kbd.p1.fire_a  <= pressed;
					key_space:     kbd.p1.fire_b  <= pressed;
					key_f1,
					key_1:         kbd.sys.start1 <= pressed;
					key_f2,
					key_2:         kbd.sys.start2 <= pressed;
					key_coin_5,
					key_coin_6:    kbd.sys.coin   <= pressed;	// One shared coin line
					key_p2_up:     kbd.p2.up      <= pressed;
					key_p2_down:   kbd.p2.down    <= pressed;
					key_p2_left:   kbd.p2.left    <= pressed;
					key_p2_right:  kbd.p2.right   <= pressed;
					key_p2_fire_a: kbd.p2.fire_a  <= pressed;
					key_p2_fire_b: kbd.p2.fire_b  <= pressed;
					default: ;	// Unknown codes are dropped
				endcase
			end
		end
	end

	// Keyboard has no key for the upper fire buttons
	a_no_upper_fire: assert property (@(posedge clk_sys) disable iff (reset)
		!(kbd.p1.fire_c || kbd.p1.fire_d || kbd.p1.fire_e ||
		  kbd.p2.fire_c || kbd.p2.fire_d || kbd.p2.fire_e))
		else $error("keyboard set an upper fire button");

endmodule

// File: hdl/port_mapper.sv
`timescale 1ns/1ps

module port_mapper
(
	input  logic                 clk_sys,
	input  logic                 reset,
	input  input_pkg::kbd_ctrl_t kbd,
	input  logic [31:0]          joy1,
	input  logic [31:0]          joy2,
	input  logic                 move_fire,
	input  game_pkg::game_e      game,
	input  game_pkg::dip_t       dip,
	output input_pkg::ports_t    ports
);
	import input_pkg::*;
	import game_pkg::*;

	player_ctrl_t p1;
	player_ctrl_t p2;
	player_ctrl_t m;	// Both players merged
	system_ctrl_t s;
	logic [31:0]  joy;
	logic [7:0]   in0;	// Active high before inversion
	logic [7:0]   in1;
	logic [7:0]   in2;
	ports_t       ports_next;

	// Joystick bits 0..8 are right, left, down, up, fire a..e
	function automatic player_ctrl_t merge_player(input player_ctrl_t k, input logic [31:0] j);
		player_ctrl_t r;
		r.right  = k.right  | j[0];
		r.left   = k.left   | j[1];
		r.down   = k.down   | j[2];
		r.up     = k.up     | j[3];
		r.fire_a = k.fire_a | j[4];
		r.fire_b = k.fire_b | j[5];
		r.fire_c = k.fire_c | j[6];
		r.fire_d = k.fire_d | j[7];
		r.fire_e = k.fire_e | j[8];
		return r;
	endfunction

	// ============================================================
	// Control merge
	// ============================================================
	assign p1  = merge_player(kbd.p1, joy1);
	assign p2  = merge_player(kbd.p2, joy2);
	assign m   = p1 | p2;
	assign joy = joy1 | joy2;

	assign s.start1 = kbd.sys.start1 | joy[joy_start1_bit];
	assign s.start2 = kbd.sys.start2 | joy[joy_start2_bit];
	assign s.coin   = kbd.sys.coin   | joy[joy_coin_bit];

	// ============================================================
	// Port layouts per game
	// ============================================================
	always_comb
	begin
		// Scramble layout also serves frogger and theend
		in0 = {s.coin, 1'b0, m.left, m.right, m.fire_a, 1'b0, m.fire_b, m.up};
		in1 = {s.start1, s.start2, m.left, m.right, m.fire_a, m.fire_b, 2'b00};
		in2 = {1'b0, m.down, 1'b0, m.up, 3'b000, m.down};

		case (game)
			game_tazman:
			begin
				in0 = {s.coin, 1'b0, m.left, m.right, m.down, m.up, m.fire_a, m.fire_b};
				in1 = 8'h00;
				in2 = {1'b0, s.start2, 5'b00000, s.start1};
			end
			game_calipso:
			begin
				in0 = {s.coin, 1'b0, m.left, m.right, m.down, m.up, 1'b0, s.start2 | m.fire_a};
				in1 = {2'b00, m.left, m.right, m.down, m.up, 2'b00};
				in2 = {7'b0000000, m.fire_a | s.start1};
			end
			game_anteater:
			begin
				in0 = {s.coin, 1'b0, m.left, m.right, m.down, m.up, 1'b0, m.fire_a};
				in1 = {1'b0, m.fire_a, m.left, m.right, m.up, m.down, 2'b00};	// Up and down swapped
				in2 = {1'b0, s.start2, 5'b00000, s.start1};
			end
			game_losttomb:
			begin
				in0 = {s.coin, 1'b0, m.left, m.right, m.down, m.up, s.start1, s.start2};
				// Move+fire puts the stick on the fire direction inputs
				if (move_fire)
					in1 = {1'b0, m.fire_e | m.fire_a, m.left, m.right, m.down, m.up, 2'b00};
				else
					in1 = {1'b0, m.fire_e, m.fire_d, m.fire_a, m.fire_b, m.fire_c, 2'b00};
				in2 = 8'h00;
			end
			game_stratgyx:
				in2 = {m.fire_c, m.down, m.fire_c, m.up, 3'b000, m.down};
			game_minefld:
			begin
				in0 = {s.coin, 1'b0, m.left, m.right, m.down, m.up, 1'b0, s.start1};
				if (move_fire)
					in1 = {2'b00, m.left, m.right, m.down, m.up, 2'b00};
				else
					in1 = {2'b00, m.fire_d, m.fire_a, m.fire_b, m.fire_c, 2'b00};
				in2 = {1'b0, s.start2, 5'b00000, s.start1};
			end
			default: ;
		endcase
	end

	// Inputs pull low and open DIP switches leave them high
	assign ports_next.port0 = dip[0] & ~in0;
	assign ports_next.port1 = dip[1] & ~in1;
	assign ports_next.port2 = dip[2] & ~in2;
	assign ports_next.port3 = dip[3];

	always_ff @(posedge clk_sys)
	begin
		if (reset)
			ports <= '1;
		else
			ports <= ports_next;
	end

	// Port 3 follows DIP byte 3 outside the four-fire games
	a_port3_dip: assert property (@(posedge clk_sys) disable iff (reset)
		!(game inside {game_losttomb, game_minefld}) |=> ports.port3 == $past(dip[3]))
		else $error("port 3 differs from DIP byte 3");

endmodule

// File: project.f
+incdir+include
hdl/input_pkg.sv
hdl/game_pkg.sv
hdl/key_event_decoder.sv
hdl/config_bank.sv
hdl/port_mapper.sv
hdl/input_ctrl_top.sv
sim/tb_input_ctrl.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f project.f --top-module tb_input_ctrl \
	-o sim_input_ctrl > sim.log 2>&1 \
	&& ./obj_dir/sim_input_ctrl >> sim.log 2>&1 \
	|| echo "build or simulation stopped early" >> sim.log
cat sim.log
grep -q "test failed" sim.log && exit 1
grep -q "test passed" sim.log || exit 1
exit 0

// File: include/tb_port_model.svh
`ifndef TB_PORT_MODEL_SVH
`define TB_PORT_MODEL_SVH

// ============================================================
// Reference model state, updated as stimulus is applied
// ============================================================
logic [8:0] mdl_p1;	// Joystick bit order, right at bit 0
logic [8:0] mdl_p2;
logic [2:0] mdl_sys;	// Coin, start2, start1 from the top
logic [7:0] mdl_game;
logic [7:0] mdl_dip [4];

task automatic model_reset();
	mdl_p1   = '0;
	mdl_p2   = '0;
	mdl_sys  = '0;
	mdl_game = 8'd0;
	for (int i = 0; i < 4; i++)
		mdl_dip[i] = 8'hFF;
endtask

// Press or release one key, arrows ignore the E0 bit
task automatic model_key(input logic [8:0] code, input logic pressed);
	logic [8:0] c;
	c = code;
	if (code[7:0] inside {8'h75, 8'h72, 8'h6B, 8'h74})
		c = {1'b0, code[7:0]};
	case (c)
		9'h075: mdl_p1[3] = pressed;
		9'h072: mdl_p1[2] = pressed;
		9'h06B: mdl_p1[1] = pressed;
		9'h074: mdl_p1[0] = pressed;
		9'h014: mdl_p1[4] = pressed;
		9'h029: mdl_p1[5] = pressed;
		9'h005, 9'h016: mdl_sys[0] = pressed;
		9'h006, 9'h01E: mdl_sys[1] = pressed;
		9'h02E, 9'h036: mdl_sys[2] = pressed;
		9'h02D: mdl_p2[3] = pressed;
		9'h02B: mdl_p2[2] = pressed;
		9'h023: mdl_p2[1] = pressed;
		9'h034: mdl_p2[0] = pressed;
		9'h01C: mdl_p2[4] = pressed;
		9'h01B: mdl_p2[5] = pressed;
		default: ;
	endcase
endtask

task automatic model_ioctl(input logic [7:0] index, input logic [24:0] addr,
	input logic [7:0] data);
	if (index == 8'd1)
		mdl_game = (data inside {8'd0, 8'd2, 8'd4, 8'd8, 8'd10, 8'd11, 8'd12, 8'd14, 8'd16})
			? data : 8'd0;
	else if (index == 8'd254 && addr < 25'd4)
		mdl_dip[addr[1:0]] = data;	// Bytes 4 and up are dropped
endtask

// Hwsel, landscape, fourfire, galaxian video, spare
function automatic logic [11:0] model_board(input logic [7:0] g);
	logic [7:0] hw;
	logic [2:0] flags;
	hw    = 8'd0;
	flags = 3'b000;
	case (g)
		8'd2:  hw = 8'd1;
		8'd4:  hw = 8'd2;
		8'd8:  hw = 8'd3;
		8'd10: hw = 8'd6;
		8'd11: {hw, flags} = {8'd7, 3'b010};
		8'd12: flags = 3'b001;
		8'd14: {hw, flags} = {8'd5, 3'b100};
		8'd16: {hw, flags} = {8'd8, 3'b010};
		default: ;
	endcase
	return {hw, flags, 1'b0};
endfunction

// Expected port bytes, port 3 in the top byte
function automatic logic [31:0] model_ports(input logic [31:0] j1, input logic [31:0] j2,
	input logic mf);
	logic [8:0]  m;
	logic [31:0] j;
	logic        st1;
	logic        st2;
	logic        coin;
	logic [7:0]  a;
	logic [7:0]  b;
	logic [7:0]  c;
	logic [7:0]  d;
	m    = mdl_p1 | j1[8:0] | mdl_p2 | j2[8:0];
	j    = j1 | j2;
	st1  = mdl_sys[0] | j[8];
	st2  = mdl_sys[1] | j[9];
	coin = mdl_sys[2] | j[10];
	a = {coin, 1'b0, m[1], m[0], m[4], 1'b0, m[5], m[3]};	// Scramble layout
	b = {st1, st2, m[1], m[0], m[4], m[5], 2'b00};
	c = {1'b0, m[2], 1'b0, m[3], 3'b000, m[2]};
	d = 8'h00;
	case (mdl_game)
		8'd4:
		begin
			a = {coin, 1'b0, m[1], m[0], m[2], m[3], m[4], m[5]};
			b = 8'h00;
			c = {1'b0, st2, 5'b00000, st1};
		end
		8'd8:
		begin
			a = {coin, 1'b0, m[1], m[0], m[2], m[3], 1'b0, st2 | m[4]};
			b = {2'b00, m[1], m[0], m[2], m[3], 2'b00};
			c = {7'b0000000, m[4] | st1};
		end
		8'd10:
		begin
			a = {coin, 1'b0, m[1], m[0], m[2], m[3], 1'b0, m[4]};
			b = {1'b0, m[4], m[1], m[0], m[3], m[2], 2'b00};
			c = {1'b0, st2, 5'b00000, st1};
		end
		8'd11:
		begin
			a = {coin, 1'b0, m[1], m[0], m[2], m[3], st1, st2};
			b = mf ? {1'b0, m[8] | m[4], m[1], m[0], m[2], m[3], 2'b00}
				: {1'b0, m[8], m[7], m[4], m[5], m[6], 2'b00};
			c = 8'h00;
		end
		8'd14: c = {m[6], m[2], m[6], m[3], 3'b000, m[2]};
		8'd16:
		begin
			a = {coin, 1'b0, m[1], m[0], m[2], m[3], 1'b0, st1};
			b = mf ? {2'b00, m[1], m[0], m[2], m[3], 2'b00}
				: {2'b00, m[7], m[4], m[5], m[6], 2'b00};
			c = {1'b0, st2, 5'b00000, st1};
		end
		default: ;
	endcase
	return {mdl_dip[3] & ~d, mdl_dip[2] & ~c, mdl_dip[1] & ~b, mdl_dip[0] & ~a};
endfunction

`endif

// File: sim/tb_input_ctrl.sv
`timescale 1ns/1ps

module tb_input_ctrl;

	localparam int settle_cycles = 4;
	localparam int settle_limit  = 12;

	// Kept key codes, arrows first
	localparam logic [8:0] key_list [18] = '{9'h075, 9'h072, 9'h06B, 9'h074, 9'h029, 9'h014,
		9'h005, 9'h006, 9'h016, 9'h01E, 9'h02E, 9'h036, 9'h02D, 9'h02B, 9'h023, 9'h034,
		9'h01C, 9'h01B};
	localparam logic [7:0] game_list [9] = '{8'd0, 8'd2, 8'd4, 8'd8, 8'd10, 8'd11, 8'd12,
		8'd14, 8'd16};

	logic        clk_sys;
	logic        reset;
	logic [10:0] ps2_key;
	logic [31:0] joy1;
	logic [31:0] joy2;
	logic        move_fire;
	logic        ioctl_wr;
	logic [7:0]  ioctl_index;
	logic [24:0] ioctl_addr;
	logic [7:0]  ioctl_dout;
	logic [31:0] ports;
	logic [11:0] board;

	logic [31:0] lfsr;
	int          errors;	// Within the running test
	int          tests_ok;
	int          tests_bad;

	`include "tb_port_model.svh"

	input_ctrl_top UUT (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.ps2_key     (ps2_key),
		.joy1        (joy1),
		.joy2        (joy2),
		.move_fire   (move_fire),
		.ioctl_wr    (ioctl_wr),
		.ioctl_index (ioctl_index),
		.ioctl_addr  (ioctl_addr),
		.ioctl_dout  (ioctl_dout),
		.ports       (ports),
		.board       (board)
	);

	always #10 clk_sys = ~clk_sys;

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic send_key(input logic [8:0] code, input logic pressed);
		@(posedge clk_sys);
		ps2_key <= {~ps2_key[10], pressed, code};	// Toggle marks a new event
		model_key(code, pressed);
	endtask

	task automatic send_ioctl(input logic [7:0] index, input logic [24:0] addr,
		input logic [7:0] data);
		@(posedge clk_sys);
		ioctl_wr    <= 1'b1;
		ioctl_index <= index;
		ioctl_addr  <= addr;
		ioctl_dout  <= data;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		model_ioctl(index, addr, data);
	endtask

	task automatic random_joys();
		logic [31:0] v;
		take_bits(32, v);
		@(posedge clk_sys);
		joy1 <= v;
		take_bits(32, v);
		joy2 <= v;
	endtask

	// At least settle_cycles, then until outputs hold for one clock
	task automatic settle();
		logic [43:0] last;
		int          n;
		last = {ports, board};
		n    = 0;
		@(negedge clk_sys);
		while (n < settle_limit && (n < settle_cycles || {ports, board} != last))
		begin
			last = {ports, board};
			@(negedge clk_sys);
			n++;
		end
		if (n == settle_limit)
		begin
			$display("At %0t the outputs kept changing for %0d cycles", $time, settle_limit);
			errors++;
		end
	endtask

	task automatic check_outputs(input string what);
		logic [31:0] exp_ports;
		logic [11:0] exp_board;
		exp_ports = model_ports(joy1, joy2, move_fire);
		exp_board = model_board(mdl_game);
		assert (ports === exp_ports)
		else
		begin
			$display("MISMATCH at %0t: %s, ports %h expected %h", $time, what, ports, exp_ports);
			errors++;
		end
		assert (board === exp_board)
		else
		begin
			$display("MISMATCH at %0t: %s, board %h expected %h", $time, what, board, exp_board);
			errors++;
		end
	endtask

	task automatic finish_test(input string name);
		if (errors == 0)
		begin
			tests_ok++;
			$display("%s: ok", name);
		end
		else
		begin
			tests_bad++;
			$display("%s: %0d errors", name, errors);
		end
		errors = 0;
	endtask

	// ============================================================
	// Test sequence
	// ============================================================
	initial
	begin
		logic [31:0] r;
		logic [31:0] v;
		logic [31:0] ext;
		logic [31:0] prs;
		logic [8:0]  code;
		lfsr        = 32'hefe90c69;
		errors      = 0;
		tests_ok    = 0;
		tests_bad   = 0;
		clk_sys     = 1'b0;
		reset       = 1'b1;
		ps2_key     = '0;
		joy1        = '0;
		joy2        = '0;
		move_fire   = 1'b0;
		ioctl_wr    = 1'b0;
		ioctl_index = '0;
		ioctl_addr  = '0;
		ioctl_dout  = '0;
		model_reset();
		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;

		settle();
		assert (ports === 32'hFFFF_FFFF && board === 12'h000)
		else
		begin
			$display("MISMATCH at %0t: reset values ports %h board %h", $time, ports, board);
			errors++;
		end
		finish_test("reset defaults");

		for (int i = 0; i < 200; i++)
		begin
			take_bits(5, r);
			take_bits(1, ext);
			take_bits(1, prs);
			if (r < 18)
				code = {ext[0], key_list[r][7:0]};
			else
			begin
				take_bits(9, v);	// Mostly codes the decoder ignores
				code = v[8:0];
			end
			send_key(code, prs[0]);
			settle();
			check_outputs("key event");
		end
		for (int k = 0; k < 18; k++)
			send_key(key_list[k], 1'b0);
		settle();
		check_outputs("key release");
		finish_test("key events");

		for (int g = 0; g < 9; g++)
		begin
			send_ioctl(8'd1, 25'd0, game_list[g]);
			for (int i = 0; i < 20; i++)
			begin
				random_joys();
				settle();
				check_outputs("joystick");
			end
		end
		finish_test("joystick merge");

		for (int i = 0; i < 40; i++)
		begin
			take_bits(2, r);
			take_bits(8, v);
			if (r == 0)
				v = {24'd0, game_list[v % 9]};
			take_bits(8, ext);
			send_ioctl((r == 2) ? ext[7:0] : 8'd1, 25'd0, v[7:0]);
			settle();
			check_outputs("game write");
		end
		finish_test("game writes");

		for (int i = 0; i < 40; i++)
		begin
			take_bits(1, r);
			take_bits(8, ext);
			take_bits(3, prs);
			take_bits(8, v);
			send_ioctl(r[0] ? 8'd254 : ext[7:0], {22'd0, prs[2:0]}, v[7:0]);
			random_joys();
			settle();
			check_outputs("dip write");
		end
		finish_test("dip writes");

		for (int a = 0; a < 4; a++)
			send_ioctl(8'd254, a[24:0], 8'hFF);
		for (int g = 0; g < 2; g++)
		begin
			send_ioctl(8'd1, 25'd0, (g == 0) ? 8'd11 : 8'd16);
			for (int i = 0; i < 20; i++)
			begin
				random_joys();
				move_fire <= ~move_fire;
				settle();
				check_outputs("move fire");
				assert (board[2] === 1'b1)
				else
				begin
					$display("MISMATCH at %0t: fourfire flag is clear", $time);
					errors++;
				end
			end
		end
		finish_test("move fire mode");

		$display("summary: %0d tests ok, %0d tests with errors", tests_ok, tests_bad);
		if (tests_bad == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule
